//--- gauntlet_pkg.sv
// Gauntlet I/O shared definitions
// Download widths, payload types, download indices, slapstic codes
// and the ROM region map of the downloaded image
`default_nettype none

package gauntlet_pkg;

	// ################################################
	// Payload types
	typedef logic [7:0]  byte_t;        // Download or audio ROM byte
	typedef logic [24:0] ioctl_addr_t;  // Download byte address
	typedef logic [7:0]  dl_index_t;
	typedef logic [7:0]  slap_type_t;
	typedef logic [63:0] dip_bank_t;    // Byte n in bits 8n+7:8n
	typedef logic [15:0] cpu_word_t;
	typedef logic [18:0] cpu_addr_t;    // CPU word address
	typedef logic [15:0] audio_addr_t;
	typedef logic [31:0] gfx_word_t;
	typedef logic [22:0] gfx_addr_t;    // Byte address / 4
	typedef logic [7:0]  player_port_t; // Active low
	typedef logic [4:0]  sys_port_t;    // Service, coin 1..4, active low

	// Download indices
	localparam dl_index_t IDX_ROM      = 8'd0;
	localparam dl_index_t IDX_SLAPSTIC = 8'd1;
	localparam dl_index_t IDX_DIP      = 8'd254;

	// Slapstic codes, one per game
	localparam slap_type_t SLAP_GAUNTLET    = 8'd104; // Reset value
	localparam slap_type_t SLAP_GAUNTLET2   = 8'd106;
	localparam slap_type_t SLAP_VINDICATORS = 8'd118; // Tank controls

	// ################################################
	// ROM regions in the download image
	localparam ioctl_addr_t CPU_9A_BASE  = 25'h00C_0000; // 64 KB
	localparam ioctl_addr_t CPU_10A_BASE = 25'h00F_0000; // 32 KB
	localparam ioctl_addr_t CPU_7A_BASE  = 25'h010_0000; // 64 KB
	localparam ioctl_addr_t CPU_6A_BASE  = 25'h011_0000;
	localparam ioctl_addr_t CPU_5A_BASE  = 25'h012_0000;
	localparam ioctl_addr_t CPU_3A_BASE  = 25'h013_0000;
	localparam ioctl_addr_t AUD_16S_BASE = 25'h014_0000; // 32 KB
	localparam ioctl_addr_t AUD_16R_BASE = 25'h014_8000; // 16 KB

	// CPU bank select, word address bits 18:15
	localparam logic [3:0] CPU_SEL_9A  = 4'd0;
	localparam logic [3:0] CPU_SEL_7A  = 4'd4;
	localparam logic [3:0] CPU_SEL_6A  = 4'd5;
	localparam logic [3:0] CPU_SEL_5A  = 4'd6;
	localparam logic [3:0] CPU_SEL_3A  = 4'd7;
	localparam logic [4:0] CPU_SEL_10A = 5'd6;  // Bits 18:14, half-size bank

endpackage

`default_nettype wire

//--- game_config_regs.sv
// Game configuration registers
// Captures the eight DIP-switch bytes and the slapstic type
// from the download stream
`timescale 1ns/1ps
`default_nettype none

module game_config_regs (
	input  wire                       clk_sys,
	input  wire                       rst_n,
	input  wire                       ioctl_wr,
	input  wire gauntlet_pkg::dl_index_t   ioctl_index,
	input  wire gauntlet_pkg::ioctl_addr_t ioctl_addr,
	input  wire gauntlet_pkg::byte_t       ioctl_dout,
	output gauntlet_pkg::dip_bank_t   dip_sw,
	output gauntlet_pkg::slap_type_t  slap_type
);

	logic dip_hit;   // DIP byte, address 0..7
	logic slap_hit;

	assign dip_hit  = ioctl_wr && (ioctl_index == gauntlet_pkg::IDX_DIP)
		&& (ioctl_addr[24:3] == '0);
	assign slap_hit = ioctl_wr && (ioctl_index == gauntlet_pkg::IDX_SLAPSTIC);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dip_sw    <= '0;
			slap_type <= gauntlet_pkg::SLAP_GAUNTLET; // Plain Gauntlet until told
		end else begin
			if (dip_hit) begin
				dip_sw[{ioctl_addr[2:0], 3'b000} +: 8] <= ioctl_dout; // Low addr bits pick the byte
			end
			if (slap_hit) begin
				slap_type <= ioctl_dout; // Any address under index 1
			end
		end
	end

endmodule

`default_nettype wire

//--- rom_download_router.sv
// ROM download router
// Keeps a short history of ROM bytes, packs graphics words on every
// fourth byte and decodes the CPU and audio ROM region writes
`timescale 1ns/1ps
`default_nettype none

module rom_download_router (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        ioctl_download,
	input  wire                        ioctl_wr,
	input  wire gauntlet_pkg::dl_index_t   ioctl_index,
	input  wire gauntlet_pkg::ioctl_addr_t ioctl_addr,
	input  wire gauntlet_pkg::byte_t       ioctl_dout,
	output logic                       gfx_wr,
	output gauntlet_pkg::gfx_addr_t    gfx_addr,
	output gauntlet_pkg::gfx_word_t    gfx_data,
	output logic [5:0]                 cpu_wr,      // Bit 0 = 9A .. bit 5 = 3A
	output logic [14:0]                cpu_wr_addr,
	output gauntlet_pkg::cpu_word_t    cpu_wr_data,
	output logic [1:0]                 aud_wr,      // Bit 0 = 16S, bit 1 = 16R
	output logic [14:0]                aud_wr_addr,
	output gauntlet_pkg::byte_t        aud_wr_data
);

	logic        rom_wr;   // ROM byte during download
	logic        last_byte; // Byte 3 of a graphics group
	logic        odd_byte;
	logic [23:0] hist;     // Three previous ROM bytes, newest lowest

	assign rom_wr = ioctl_wr && ioctl_download && (ioctl_index == gauntlet_pkg::IDX_ROM);
	assign last_byte = rom_wr && (ioctl_addr[1:0] == 2'b11);
	assign odd_byte  = rom_wr && ioctl_addr[0];   // CPU words complete on odd bytes

	always_ff @(posedge clk_sys) begin
		if (rom_wr) begin
			hist <= {hist[15:0], ioctl_dout};
		end
	end

	// ################################################
	// Graphics word packer
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			gfx_wr <= 1'b0;
		end else begin
			gfx_wr <= last_byte; // One pulse per group
		end
	end

	always_ff @(posedge clk_sys) begin
		if (last_byte) begin
			gfx_data <= {hist, ioctl_dout}; // Oldest byte highest
			gfx_addr <= ioctl_addr[24:2];
		end
	end

	// ################################################
	// Region decode, one strobe at most
	assign cpu_wr[0] = odd_byte && (ioctl_addr[24:16] == gauntlet_pkg::CPU_9A_BASE[24:16]);
	assign cpu_wr[1] = odd_byte && (ioctl_addr[24:15] == gauntlet_pkg::CPU_10A_BASE[24:15]);
	assign cpu_wr[2] = odd_byte && (ioctl_addr[24:16] == gauntlet_pkg::CPU_7A_BASE[24:16]);
	assign cpu_wr[3] = odd_byte && (ioctl_addr[24:16] == gauntlet_pkg::CPU_6A_BASE[24:16]);
	assign cpu_wr[4] = odd_byte && (ioctl_addr[24:16] == gauntlet_pkg::CPU_5A_BASE[24:16]);
	assign cpu_wr[5] = odd_byte && (ioctl_addr[24:16] == gauntlet_pkg::CPU_3A_BASE[24:16]);
	assign aud_wr[0] = rom_wr && (ioctl_addr[24:15] == gauntlet_pkg::AUD_16S_BASE[24:15]);
	assign aud_wr[1] = rom_wr && (ioctl_addr[24:14] == gauntlet_pkg::AUD_16R_BASE[24:14]);

	assign cpu_wr_addr = ioctl_addr[15:1];            // Word address
	assign cpu_wr_data = {hist[7:0], ioctl_dout};     // Even byte high
	assign aud_wr_addr = ioctl_addr[14:0];
	assign aud_wr_data = ioctl_dout;

endmodule

`default_nettype wire

//--- rom_bank_store.sv
// ROM bank store
// Simple dual-port memory, download write port and registered read
`timescale 1ns/1ps
`default_nettype none

module rom_bank_store #(
	parameter int  ADDR_W = 15,
	parameter type DATA_T = gauntlet_pkg::cpu_word_t
) (
	input  wire              clk_sys,
	input  wire              wr,
	input  wire [ADDR_W-1:0] wr_addr,
	input  wire DATA_T       wr_data,
	input  wire [ADDR_W-1:0] rd_addr,
	output DATA_T            rd_data
);

	DATA_T mem [2**ADDR_W]; // Filled only by download

	always_ff @(posedge clk_sys) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr]; // One cycle read latency
	end

endmodule

`default_nettype wire

//--- program_rom_array.sv
// Program ROM array
// Six CPU program banks and two audio banks, with the read-side
// bank select registered beside the bank reads
`timescale 1ns/1ps
`default_nettype none

module program_rom_array (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire [5:0]                    cpu_wr,
	input  wire [14:0]                   cpu_wr_addr,
	input  wire gauntlet_pkg::cpu_word_t     cpu_wr_data,
	input  wire [1:0]                    aud_wr,
	input  wire [14:0]                   aud_wr_addr,
	input  wire gauntlet_pkg::byte_t         aud_wr_data,
	input  wire gauntlet_pkg::cpu_addr_t     cpu_addr,
	input  wire gauntlet_pkg::audio_addr_t   audio_addr,
	output gauntlet_pkg::cpu_word_t      cpu_data,
	output gauntlet_pkg::byte_t          audio_data
);

	gauntlet_pkg::cpu_word_t cpu_bank_data [6];
	gauntlet_pkg::byte_t     aud_bank_data [2];
	logic [2:0] cpu_sel;    // Bank index, 7 = unmapped
	logic [2:0] cpu_sel_q;
	logic       aud_sel_q;  // 1 = 16S

	// ################################################
	// Banks, 10A and 16R are half size
	for (genvar i = 0; i < 6; i++) begin : g_cpu
		localparam int AW = (i == 1) ? 14 : 15;
		rom_bank_store #(
			.ADDR_W(AW),
			.DATA_T(gauntlet_pkg::cpu_word_t)
		) cpu_bank_inst (
			.clk_sys(clk_sys),
			.wr     (cpu_wr[i]),
			.wr_addr(cpu_wr_addr[AW-1:0]),
			.wr_data(cpu_wr_data),
			.rd_addr(cpu_addr[AW-1:0]),
			.rd_data(cpu_bank_data[i])
		);
	end

	for (genvar i = 0; i < 2; i++) begin : g_aud
		localparam int AW = (i == 0) ? 15 : 14;
		rom_bank_store #(
			.ADDR_W(AW),
			.DATA_T(gauntlet_pkg::byte_t)
		) aud_bank_inst (
			.clk_sys(clk_sys),
			.wr     (aud_wr[i]),
			.wr_addr(aud_wr_addr[AW-1:0]),
			.wr_data(aud_wr_data),
			.rd_addr(audio_addr[AW-1:0]),
			.rd_data(aud_bank_data[i])
		);
	end

	// ################################################
	// Read select, same cycle as the bank read
	always_comb begin
		case (cpu_addr[18:15])
			gauntlet_pkg::CPU_SEL_9A: cpu_sel = 3'd0;
			gauntlet_pkg::CPU_SEL_7A: cpu_sel = 3'd2;
			gauntlet_pkg::CPU_SEL_6A: cpu_sel = 3'd3;
			gauntlet_pkg::CPU_SEL_5A: cpu_sel = 3'd4;
			gauntlet_pkg::CPU_SEL_3A: cpu_sel = 3'd5;
			default: cpu_sel = (cpu_addr[18:14] == gauntlet_pkg::CPU_SEL_10A) ? 3'd1 : 3'd7;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cpu_sel_q <= 3'd7;
			aud_sel_q <= 1'b0;
		end else begin
			cpu_sel_q <= cpu_sel;
			aud_sel_q <= audio_addr[15];
		end
	end

	assign cpu_data   = (cpu_sel_q < 3'd6) ? cpu_bank_data[cpu_sel_q] : '0; // Holes read zero
	assign audio_data = aud_sel_q ? aud_bank_data[0] : aud_bank_data[1];

endmodule

`default_nettype wire

//--- player_input_map.sv
// Player input mapper
// Latches keyboard events, decodes tank joysticks and builds the
// active-low player and coin ports for the selected layout
`timescale 1ns/1ps
`default_nettype none

module player_input_map (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire [10:0]                  ps2_key,
	input  wire [15:0]                  joy0,
	input  wire [15:0]                  joy1,
	input  wire [15:0]                  joy2,
	input  wire [15:0]                  joy3,
	input  wire                         service,
	input  wire gauntlet_pkg::slap_type_t   slap_type,
	output gauntlet_pkg::player_port_t  p1,
	output gauntlet_pkg::player_port_t  p2,
	output gauntlet_pkg::player_port_t  p3,
	output gauntlet_pkg::player_port_t  p4,
	output gauntlet_pkg::sys_port_t     sys_port
);

	logic        tank;        // Vindicators layout
	logic [10:0] key_q;       // Sampled ps2_key
	logic        key_tgl_q;
	logic        key_event;
	logic        pressed;
	logic [7:0]  key_p1, key_p2, key_p3, key_p4;
	logic [3:0]  key_coin;    // Bit 3 = coin 1, as on sys_port
	logic [7:0]  joy_p1_q, joy_p2_q, joy_p3_q, joy_p4_q;
	logic [3:0]  joy_coin_q;

	// Up, down, left, right in; {r back, l back, r fwd, l fwd} out
	function automatic logic [3:0] tank_decode(input logic [3:0] dir);
		case (dir)
			4'b1010: tank_decode = 4'b0010; // Up left
			4'b1000: tank_decode = 4'b0011; // Up
			4'b1001: tank_decode = 4'b0001; // Up right
			4'b0001: tank_decode = 4'b1001; // Right, spin
			4'b0101: tank_decode = 4'b0100; // Down right
			4'b0100: tank_decode = 4'b1100; // Down
			4'b0110: tank_decode = 4'b1000; // Down left
			4'b0010: tank_decode = 4'b0110; // Left, spin
			default: tank_decode = 4'b0000;
		endcase
	endfunction

	assign tank      = (slap_type == gauntlet_pkg::SLAP_VINDICATORS);
	assign key_event = key_q[10] != key_tgl_q; // Toggle marks a new event
	assign pressed   = key_q[9];

	// ################################################
	// Keyboard latch
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			key_q     <= '0;
			key_tgl_q <= 1'b0;
			key_p1    <= '0;
			key_p2    <= '0;
			key_p3    <= '0;
			key_p4    <= '0;
			key_coin  <= '0;
		end else begin
			key_q     <= ps2_key;
			key_tgl_q <= key_q[10];
			if (key_event && tank) begin
				case (key_q[8:0])
					9'h023: key_p1[7] <= pressed; // D, right tread back
					9'h01B: key_p1[6] <= pressed; // S, left tread back
					9'h024: key_p1[5] <= pressed; // E
					9'h01D: key_p1[4] <= pressed; // W
					9'h02D: key_p1[3] <= pressed; // R, thumb
					9'h015: key_p1[2] <= pressed; // Q
					9'h02B: key_p1[1] <= pressed; // F, trigger
					9'h01C: key_p1[0] <= pressed; // A
					9'h042: key_p2[7] <= pressed; // K
					9'h03B: key_p2[6] <= pressed; // J
					9'h043: key_p2[5] <= pressed; // I
					9'h03C: key_p2[4] <= pressed; // U
					9'h044: key_p2[3] <= pressed; // O
					9'h035: key_p2[2] <= pressed; // Y
					9'h04B: key_p2[1] <= pressed; // L
					9'h033: key_p2[0] <= pressed; // H
					9'h016: key_p3[0] <= pressed; // 1, P1 start
					9'h01E: key_p3[1] <= pressed; // 2, P2 start
					9'h02E: key_coin[3] <= pressed;
					9'h036: key_coin[2] <= pressed;
					default: ;
				endcase
			end else if (key_event) begin
				case (key_q[8:0])
					9'h175: key_p1[7] <= pressed; // Arrows
					9'h172: key_p1[6] <= pressed;
					9'h16B: key_p1[5] <= pressed;
					9'h174: key_p1[4] <= pressed;
					9'h014: key_p1[1] <= pressed; // Left ctrl, fire
					9'h011: key_p1[0] <= pressed; // Left alt, magic
					9'h02D: key_p2[7] <= pressed; // R F D G
					9'h02B: key_p2[6] <= pressed;
					9'h023: key_p2[5] <= pressed;
					9'h034: key_p2[4] <= pressed;
					9'h01C: key_p2[1] <= pressed; // A
					9'h01B: key_p2[0] <= pressed; // S
					9'h043: key_p3[7] <= pressed; // I K J L
					9'h042: key_p3[6] <= pressed;
					9'h03B: key_p3[5] <= pressed;
					9'h04B: key_p3[4] <= pressed;
					9'h114: key_p3[1] <= pressed; // Right ctrl
					9'h059: key_p3[0] <= pressed; // Right shift
					9'h075: key_p4[7] <= pressed; // Numpad 8 2 4 6
					9'h072: key_p4[6] <= pressed;
					9'h06B: key_p4[5] <= pressed;
					9'h074: key_p4[4] <= pressed;
					9'h070: key_p4[1] <= pressed; // Numpad 0
					9'h071: key_p4[0] <= pressed; // Numpad dot
					9'h02E: key_coin[3] <= pressed; // Keys 5..8
					9'h036: key_coin[2] <= pressed;
					9'h03D: key_coin[1] <= pressed;
					9'h03E: key_coin[0] <= pressed;
					default: ;
				endcase
			end
		end
	end

	// ################################################
	// Joystick contribution, one register stage
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			joy_p1_q   <= '0;
			joy_p2_q   <= '0;
			joy_p3_q   <= '0;
			joy_p4_q   <= '0;
			joy_coin_q <= '0;
		end else begin
			if (tank) begin
				joy_p1_q <= {tank_decode(joy0[3:0]), joy0[7:4]};
				joy_p2_q <= {tank_decode(joy1[3:0]), joy1[7:4]};
				joy_p3_q <= {6'b0, joy1[9], joy0[9]}; // Start buttons
				joy_p4_q <= '0;
			end else begin
				joy_p1_q <= {joy0[3:0], joy0[7:4]}; // Directions high, buttons low
				joy_p2_q <= {joy1[3:0], joy1[7:4]};
				joy_p3_q <= {joy2[3:0], joy2[7:4]};
				joy_p4_q <= {joy3[3:0], joy3[7:4]};
			end
			joy_coin_q <= {joy0[8], joy1[8], joy2[8], joy3[8]};
		end
	end

	assign p1 = ~(key_p1 | joy_p1_q);
	assign p2 = ~(key_p2 | joy_p2_q);
	assign p3 = ~(key_p3 | joy_p3_q);
	assign p4 = ~(key_p4 | joy_p4_q);
	assign sys_port = {~service, ~(key_coin | joy_coin_q)};

endmodule

`default_nettype wire

//--- gauntlet_io_top.sv
// Gauntlet I/O top level
// Download loader, ROM stores, configuration registers and
// player input mapping
`timescale 1ns/1ps
`default_nettype none

module gauntlet_io_top (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire                          ioctl_download,
	input  wire                          ioctl_wr,
	input  wire gauntlet_pkg::dl_index_t     ioctl_index,
	input  wire gauntlet_pkg::ioctl_addr_t   ioctl_addr,
	input  wire gauntlet_pkg::byte_t         ioctl_dout,
	output gauntlet_pkg::dip_bank_t      dip_sw,
	output gauntlet_pkg::slap_type_t     slap_type,
	output logic                         gfx_wr,
	output gauntlet_pkg::gfx_addr_t      gfx_addr,
	output gauntlet_pkg::gfx_word_t      gfx_data,
	input  wire gauntlet_pkg::cpu_addr_t     cpu_addr,
	output gauntlet_pkg::cpu_word_t      cpu_data,
	input  wire gauntlet_pkg::audio_addr_t   audio_addr,
	output gauntlet_pkg::byte_t          audio_data,
	input  wire [10:0]                   ps2_key,
	input  wire [15:0]                   joy0,
	input  wire [15:0]                   joy1,
	input  wire [15:0]                   joy2,
	input  wire [15:0]                   joy3,
	input  wire                          service,
	output gauntlet_pkg::player_port_t   p1,
	output gauntlet_pkg::player_port_t   p2,
	output gauntlet_pkg::player_port_t   p3,
	output gauntlet_pkg::player_port_t   p4,
	output gauntlet_pkg::sys_port_t      sys_port
);

	logic [5:0]              cpu_wr;
	logic [14:0]             cpu_wr_addr;
	gauntlet_pkg::cpu_word_t cpu_wr_data;
	logic [1:0]              aud_wr;
	logic [14:0]             aud_wr_addr;
	gauntlet_pkg::byte_t     aud_wr_data;

	game_config_regs game_config_regs_inst (
		.clk_sys, .rst_n, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.dip_sw, .slap_type
	);

	rom_download_router rom_download_router_inst (
		.clk_sys, .rst_n, .ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr,
		.ioctl_dout, .gfx_wr, .gfx_addr, .gfx_data, .cpu_wr, .cpu_wr_addr,
		.cpu_wr_data, .aud_wr, .aud_wr_addr, .aud_wr_data
	);

	program_rom_array program_rom_array_inst (
		.clk_sys, .rst_n, .cpu_wr, .cpu_wr_addr, .cpu_wr_data, .aud_wr,
		.aud_wr_addr, .aud_wr_data, .cpu_addr, .audio_addr, .cpu_data, .audio_data
	);

	// Layout follows the slapstic type
	player_input_map player_input_map_inst (
		.clk_sys, .rst_n, .ps2_key, .joy0, .joy1, .joy2, .joy3, .service,
		.slap_type, .p1, .p2, .p3, .p4, .sys_port
	);

endmodule

`default_nettype wire

//--- tb_gauntlet_io.sv
// Gauntlet I/O testbench
// Directed tests of the config registers, ROM download and readback,
// graphics word packing and both player input layouts
`timescale 1ns/1ps
`default_nettype none

module tb_gauntlet_io;

	localparam int BYTES_SENT      = 81;
	localparam int WATCHDOG_CYCLES = BYTES_SENT * 10 + 1000; // Margin for key and joystick tests

	logic                        clk_sys;
	logic                        rst_n;
	logic                        ioctl_download;
	logic                        ioctl_wr;
	gauntlet_pkg::dl_index_t     ioctl_index;
	gauntlet_pkg::ioctl_addr_t   ioctl_addr;
	gauntlet_pkg::byte_t         ioctl_dout;
	gauntlet_pkg::dip_bank_t     dip_sw;
	gauntlet_pkg::slap_type_t    slap_type;
	logic                        gfx_wr;
	gauntlet_pkg::gfx_addr_t     gfx_addr;
	gauntlet_pkg::gfx_word_t     gfx_data;
	gauntlet_pkg::cpu_addr_t     cpu_addr;
	gauntlet_pkg::cpu_word_t     cpu_data;
	gauntlet_pkg::audio_addr_t   audio_addr;
	gauntlet_pkg::byte_t         audio_data;
	logic [10:0]                 ps2_key;
	logic [15:0]                 joy [4];
	logic                        service;
	gauntlet_pkg::player_port_t  p1, p2, p3, p4;
	gauntlet_pkg::sys_port_t     sys_port;

	int          errors;
	int          checks;
	logic [31:0] lfsr_state;
	logic        key_tgl;    // Event toggle on ps2_key bit 10
	logic [23:0] rom_hist;   // Last three ROM bytes with the newest lowest

	// Key tables as {port, port bit, scan code} with port 4 as sys_port
	logic [19:0] gauntlet_keys [28] = '{
		20'h07175, 20'h06172, 20'h0516B, 20'h04174, 20'h01014, 20'h00011,
		20'h1702D, 20'h1602B, 20'h15023, 20'h14034, 20'h1101C, 20'h1001B,
		20'h27043, 20'h26042, 20'h2503B, 20'h2404B, 20'h21114, 20'h20059,
		20'h37075, 20'h36072, 20'h3506B, 20'h34074, 20'h31070, 20'h30071,
		20'h4302E, 20'h42036, 20'h4103D, 20'h4003E};
	logic [19:0] tank_keys [20] = '{
		20'h07023, 20'h0601B, 20'h05024, 20'h0401D, 20'h0302D, 20'h02015, 20'h0102B,
		20'h0001C, 20'h17042, 20'h1603B, 20'h15043, 20'h1403C, 20'h13044, 20'h12035,
		20'h1104B, 20'h10033, 20'h20016, 20'h2101E, 20'h4302E, 20'h42036};

	gauntlet_io_top gauntlet_io_top_inst (
		.clk_sys, .rst_n, .ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr,
		.ioctl_dout, .dip_sw, .slap_type, .gfx_wr, .gfx_addr, .gfx_data, .cpu_addr,
		.cpu_data, .audio_addr, .audio_data, .ps2_key, .joy0(joy[0]), .joy1(joy[1]),
		.joy2(joy[2]), .joy3(joy[3]), .service, .p1, .p2, .p3, .p4, .sys_port
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	// ################################################
	// Stimulus helpers
	function automatic gauntlet_pkg::byte_t next_byte();
		gauntlet_pkg::byte_t b;
		logic                fb;
		int                  i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]; // Taps 32 22 2 1
			lfsr_state = {lfsr_state[30:0], fb};
			b = {b[6:0], fb};
		end
		return b;
	endfunction

	// Expected tread bits {r back, l back, r fwd, l fwd} for a stick direction
	function automatic logic [3:0] tread_expect(input logic [3:0] dir);
		int fwd;
		int turn;
		int l;
		int r;
		fwd  = int'(dir[3]) - int'(dir[2]);
		turn = int'(dir[0]) - int'(dir[1]);
		if (fwd < 0)
			turn = -turn; // Steering flips in reverse
		l = fwd + turn;
		r = fwd - turn;
		return {r < 0, l < 0, r > 0, l > 0};
	endfunction

	function automatic gauntlet_pkg::ioctl_addr_t cpu_base(input int r);
		case (r)
			0: return gauntlet_pkg::CPU_9A_BASE;
			1: return gauntlet_pkg::CPU_10A_BASE;
			2: return gauntlet_pkg::CPU_7A_BASE;
			3: return gauntlet_pkg::CPU_6A_BASE;
			4: return gauntlet_pkg::CPU_5A_BASE;
			default: return gauntlet_pkg::CPU_3A_BASE;
		endcase
	endfunction

	function automatic gauntlet_pkg::cpu_addr_t cpu_rd_base(input int r);
		case (r)
			0: return 19'h00000;                           // 9A
			1: return 19'h18000;                           // 10A has bits 18:14 = 6
			default: return gauntlet_pkg::cpu_addr_t'((r + 2) << 15); // Codes 4..7
		endcase
	endfunction

	task automatic send_byte(input gauntlet_pkg::dl_index_t idx,
			input gauntlet_pkg::ioctl_addr_t addr, input gauntlet_pkg::byte_t data);
		ioctl_wr    = 1'b1;
		ioctl_index = idx;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		key_tgl = ~key_tgl;
		ps2_key = {key_tgl, pressed, code};
		repeat (2) @(negedge clk_sys); // Input sample and latch stages
	endtask

	// ################################################
	// Checks
	task automatic check_word(input gauntlet_pkg::cpu_word_t got,
			input gauntlet_pkg::cpu_word_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_byte(input gauntlet_pkg::byte_t got,
			input gauntlet_pkg::byte_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_slap(input gauntlet_pkg::slap_type_t got,
			input gauntlet_pkg::slap_type_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, msg, got, exp);
		end
	endtask

	task automatic check_dip(input gauntlet_pkg::dip_bank_t got,
			input gauntlet_pkg::dip_bank_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_port(input gauntlet_pkg::player_port_t got,
			input gauntlet_pkg::player_port_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_sys(input gauntlet_pkg::sys_port_t got,
			input gauntlet_pkg::sys_port_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_gfx(input logic got_wr, input gauntlet_pkg::gfx_addr_t got_addr,
			input gauntlet_pkg::gfx_word_t got_data, input logic exp_wr,
			input gauntlet_pkg::gfx_addr_t exp_addr, input gauntlet_pkg::gfx_word_t exp_data,
			input string msg);
		checks++;
		if (got_wr !== exp_wr || (exp_wr && (got_addr !== exp_addr || got_data !== exp_data))) begin
			errors++;
			$display("mismatch at %0t: %s got wr %b addr %h data %h expected wr %b addr %h data %h",
				$time, msg, got_wr, got_addr, got_data, exp_wr, exp_addr, exp_data);
		end
	endtask

	task automatic check_ports(input gauntlet_pkg::player_port_t e1, e2, e3, e4,
			input gauntlet_pkg::sys_port_t es, input string msg);
		check_port(p1, e1, {msg, " p1"});
		check_port(p2, e2, {msg, " p2"});
		check_port(p3, e3, {msg, " p3"});
		check_port(p4, e4, {msg, " p4"});
		check_sys(sys_port, es, {msg, " sys"});
	endtask

	// Exactly one active-low bit where port 4 means sys_port
	task automatic check_one_low(input int port, input int pbit, input string msg);
		gauntlet_pkg::player_port_t e [4];
		gauntlet_pkg::sys_port_t    es;
		int                         i;
		for (i = 0; i < 4; i++)
			e[i] = 8'hFF;
		es = 5'h1F;
		if (port == 4)
			es[pbit] = 1'b0;
		else
			e[port][pbit] = 1'b0;
		check_ports(e[0], e[1], e[2], e[3], es, msg);
	endtask

	task automatic key_test(input logic [8:0] code, input int port, input int pbit,
			input string msg);
		send_key(code, 1'b1);
		check_one_low(port, pbit, msg);
		send_key(code, 1'b0); // Release restores the bit
		check_ports(8'hFF, 8'hFF, 8'hFF, 8'hFF, 5'h1F, {msg, " release"});
	endtask

	task automatic joy_single(input int n, input logic [15:0] val, input int port,
			input int pbit, input string msg);
		joy[n] = val;
		@(negedge clk_sys);
		check_one_low(port, pbit, msg);
		joy[n] = '0;
		@(negedge clk_sys);
		check_ports(8'hFF, 8'hFF, 8'hFF, 8'hFF, 5'h1F, {msg, " idle"});
	endtask

	// ROM byte with graphics word prediction
	task automatic send_rom_byte(input gauntlet_pkg::ioctl_addr_t addr,
			input gauntlet_pkg::byte_t data);
		logic                    exp_wr;
		gauntlet_pkg::gfx_word_t exp_data;
		exp_wr   = ioctl_download && (addr[1:0] == 2'b11);
		exp_data = {rom_hist, data}; // Oldest byte highest
		if (ioctl_download)
			rom_hist = {rom_hist[15:0], data};
		send_byte(gauntlet_pkg::IDX_ROM, addr, data);
		check_gfx(gfx_wr, gfx_addr, gfx_data, exp_wr, gauntlet_pkg::gfx_addr_t'(addr >> 2),
			exp_data, "graphics word");
	endtask

	// ################################################
	// Tests
	task automatic test_reset_state();
		check_dip(dip_sw, '0, "dip_sw after reset");
		check_slap(slap_type, gauntlet_pkg::SLAP_GAUNTLET, "slap_type after reset");
		check_ports(8'hFF, 8'hFF, 8'hFF, 8'hFF, 5'h1F, "ports after reset");
		repeat (3) begin
			check_gfx(gfx_wr, gfx_addr, gfx_data, 1'b0, '0, '0, "gfx_wr after reset");
			@(negedge clk_sys);
		end
	endtask

	task automatic test_config_regs();
		gauntlet_pkg::dip_bank_t exp_dip;
		gauntlet_pkg::byte_t     b;
		int                      a;
		exp_dip = '0;
		ioctl_download = 1'b1;
		for (a = 0; a < 8; a++) begin
			b = next_byte();
			send_byte(gauntlet_pkg::IDX_DIP, a, b);
			exp_dip[8*a +: 8] = b;
			check_dip(dip_sw, exp_dip, "dip byte");
		end
		send_byte(gauntlet_pkg::IDX_DIP, 25'd8, 8'hA5); // Outside the eight bytes
		check_dip(dip_sw, exp_dip, "dip above address 7");
		send_byte(gauntlet_pkg::IDX_SLAPSTIC, '0, gauntlet_pkg::SLAP_VINDICATORS);
		check_slap(slap_type, gauntlet_pkg::SLAP_VINDICATORS, "slap_type 118");
		send_byte(gauntlet_pkg::IDX_SLAPSTIC, '0, gauntlet_pkg::SLAP_GAUNTLET);
		check_slap(slap_type, gauntlet_pkg::SLAP_GAUNTLET, "slap_type 104");
		ioctl_download = 1'b0;
	endtask

	task automatic test_rom_banks();
		gauntlet_pkg::cpu_word_t exp_w [6][4];
		gauntlet_pkg::byte_t     exp_b [2][4];
		gauntlet_pkg::byte_t     hi;
		gauntlet_pkg::byte_t     lo;
		int                      r;
		int                      w;
		ioctl_download = 1'b1;
		for (r = 0; r < 6; r++) begin
			for (w = 0; w < 4; w++) begin
				hi = next_byte();
				lo = next_byte();
				send_rom_byte(cpu_base(r) + 2 * w, hi);     // Even byte is the high half
				send_rom_byte(cpu_base(r) + 2 * w + 1, lo);
				exp_w[r][w] = {hi, lo};
			end
		end
		for (r = 0; r < 2; r++) begin
			for (w = 0; w < 4; w++) begin
				exp_b[r][w] = next_byte();
				send_rom_byte((r == 0 ? gauntlet_pkg::AUD_16S_BASE : gauntlet_pkg::AUD_16R_BASE)
					+ w, exp_b[r][w]);
			end
		end
		ioctl_download = 1'b0;
		for (r = 0; r < 6; r++) begin
			for (w = 0; w < 4; w++) begin
				cpu_addr = cpu_rd_base(r) + w;
				@(negedge clk_sys);
				check_word(cpu_data, exp_w[r][w], "cpu read");
			end
		end
		for (r = 0; r < 2; r++) begin
			for (w = 0; w < 4; w++) begin
				audio_addr = (r == 0 ? 16'h8000 : 16'h0000) + w; // Bit 15 picks 16S
				@(negedge clk_sys);
				check_byte(audio_data, exp_b[r][w], "audio read");
			end
		end
		cpu_addr = 19'h08000; // Code 1 maps to no bank
		@(negedge clk_sys);
		check_word(cpu_data, '0, "unmapped cpu read");
	endtask

	task automatic test_gfx_packer();
		int a;
		ioctl_download = 1'b1;
		for (a = 0; a < 8; a++)
			send_rom_byte(25'h100 + a, next_byte());
		ioctl_download = 1'b0; // No pulses and no history
		for (a = 8; a < 12; a++)
			send_rom_byte(25'h100 + a, next_byte());
		ioctl_download = 1'b1;
		send_rom_byte(25'h10F, next_byte());
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_gfx(gfx_wr, gfx_addr, gfx_data, 1'b0, '0, '0, "gfx_wr single pulse");
	endtask

	task automatic test_gauntlet_inputs();
		int i;
		int n;
		int k;
		for (i = 0; i < 28; i++)
			key_test(gauntlet_keys[i][8:0], gauntlet_keys[i][19:16], gauntlet_keys[i][15:12],
				"gauntlet key");
		for (n = 0; n < 4; n++) begin
			for (k = 0; k < 9; k++)
				joy_single(n, 16'h1 << k, (k == 8) ? 4 : n,
					(k == 8) ? 3 - n : ((k < 4) ? k + 4 : k - 4), "gauntlet joystick");
		end
		service = 1'b1;
		@(negedge clk_sys);
		check_sys(sys_port, 5'h0F, "service");
		service = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic test_tank_inputs();
		gauntlet_pkg::player_port_t e [4];
		logic [3:0]                 dir;
		int                         i;
		int                         n;
		int                         d;
		send_byte(gauntlet_pkg::IDX_SLAPSTIC, '0, gauntlet_pkg::SLAP_VINDICATORS);
		check_slap(slap_type, gauntlet_pkg::SLAP_VINDICATORS, "tank slap_type");
		@(negedge clk_sys);
		check_ports(8'hFF, 8'hFF, 8'hFF, 8'hFF, 5'h1F, "tank idle");
		for (n = 0; n < 2; n++) begin
			for (d = 1; d < 16; d++) begin
				dir = d[3:0];
				if ((dir[3] && dir[2]) || (dir[1] && dir[0]))
					continue; // Only the eight directions
				joy[n] = {12'h0, dir};
				@(negedge clk_sys);
				for (i = 0; i < 4; i++)
					e[i] = 8'hFF;
				e[n] = ~{tread_expect(dir), 4'h0};
				check_ports(e[0], e[1], e[2], e[3], 5'h1F, "tank direction");
				joy[n] = '0;
				@(negedge clk_sys);
			end
		end
		joy_single(0, 16'h0010, 0, 0, "tank p1 button");
		joy_single(1, 16'h0080, 1, 3, "tank p2 button");
		joy_single(0, 16'h0200, 2, 0, "p1 start");
		joy_single(1, 16'h0200, 2, 1, "p2 start");
		joy_single(1, 16'h0100, 4, 2, "tank coin 2");
		for (i = 0; i < 20; i++)
			key_test(tank_keys[i][8:0], tank_keys[i][19:16], tank_keys[i][15:12], "tank key");
	endtask

	// ################################################
	// Main sequence
	initial begin
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		cpu_addr       = '0;
		audio_addr     = '0;
		ps2_key        = '0;
		for (int j = 0; j < 4; j++)
			joy[j] = '0;
		service    = 1'b0;
		key_tgl    = 1'b0;
		rom_hist   = '0;
		lfsr_state = 32'h3efd8194;
		errors     = 0;
		checks     = 0;
		repeat (2) @(posedge clk_sys); // Two reset cycles
		@(negedge clk_sys);
		rst_n = 1'b1;
		test_reset_state();
		test_config_regs();
		test_rom_banks();
		test_gfx_packer();
		test_gauntlet_inputs();
		test_tank_inputs();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
gauntlet_pkg.sv
game_config_regs.sv
rom_download_router.sv
rom_bank_store.sv
program_rom_array.sv
player_input_map.sv
gauntlet_io_top.sv
tb_gauntlet_io.sv
